// File: bench/src_top_tb.sv
`timescale 1ns/1ps
`include "src_macros.svh"

module src_top_tb;

    localparam int TOTAL_BLOCKS = 12;
    localparam int LIMIT_CYCLES = TOTAL_BLOCKS * 200 + 1000;

    typedef logic [31:0] block_t [0:2*`SRC_BLOCK_WORDS-1];

    logic              clk;
    logic              rst;
    logic              in_valid;
    logic              in_ready;
    logic [63:0]       in_data;
    src_pkg::src_op_t  in_op;
    logic              res_valid;
    logic              res_ready;
    logic [31:0]       res_data;

    integer            seed;
    int                errors;
    int                checks;
    int                tests_run;
    int                mark;
    block_t            blk_words;
    logic [31:0]       exp_q [$];
    string             name_q [$];

    tb_clock u_clock (
        .clk (clk),
        .rst (rst)
    );

    src_top DUT (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (in_data),
        .in_op     (in_op),
        .res_valid (res_valid),
        .res_ready (res_ready),
        .res_data  (res_data)
    );

    // expected result of one block, straight from the opcode rules
    function automatic logic [31:0] ref_reduce(input src_pkg::src_op_t op, input block_t w);
        logic [31:0] r;
        int          i;
        r = 32'd0;
        for (i = 0; i < 2 * `SRC_BLOCK_WORDS; i++) begin
            if (op == src_pkg::OP_SUM) begin
                r = r + w[i];
            end else if (op == src_pkg::OP_XOR) begin
                r = r ^ w[i];
            end else if (w[i] > r) begin
                r = w[i];
            end
        end
        return r;
    endfunction

    task check_value(input string name, input logic [31:0] expected, input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Error: %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task fill_random;
        int i;
        for (i = 0; i < 2 * `SRC_BLOCK_WORDS; i++) begin
            blk_words[i] = $random(seed);
        end
    endtask

    // beats go out on falling edges, gaps and op noise only when asked
    task drive_block(input src_pkg::src_op_t op, input bit gaps);
        int i;
        for (i = 0; i < `SRC_BLOCK_WORDS; i++) begin
            @(negedge clk);
            while (gaps && ({$random(seed)} % 3) == 0) begin
                in_valid = 1'b0;
                @(negedge clk);
            end
            in_valid = 1'b1;
            in_data  = {blk_words[2*i+1], blk_words[2*i]};
            if (i == 0 || !gaps) begin
                in_op = op;
            end else begin
                in_op = src_pkg::src_op_t'(2'({$random(seed)} % 3));
            end
            while (!in_ready) @(negedge clk);
            @(posedge clk);
        end
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task send_block(input src_pkg::src_op_t op, input bit gaps, input string name);
        exp_q.push_back(ref_reduce(op, blk_words));
        name_q.push_back(name);
        drive_block(op, gaps);
    endtask

    task wait_results;
        while (exp_q.size() != 0) @(negedge clk);
    endtask

    task report_test(input string name);
        tests_run++;
        $display("test %s: %s", name, (errors == mark) ? "ok" : "FAILED");
        mark = errors;
    endtask

    task run_backpressure;
        int hold;
        hold = 150 + ({$random(seed)} % 200);
        @(negedge clk);
        res_ready = 1'b0;
        fork
            begin
                fill_random;
                send_block(src_pkg::OP_MAX, 1'b0, "backpressure");
                fill_random;
                send_block(src_pkg::OP_SUM, 1'b0, "backpressure");
                fill_random;
                send_block(src_pkg::OP_XOR, 1'b0, "backpressure");
            end
            begin
                repeat (hold) @(negedge clk);
                // second block is parked in the write bank by now
                check_value("backpressure in_ready", 32'd0, 32'(in_ready));
                check_value("backpressure res_valid", 32'd1, 32'(res_valid));
                res_ready = 1'b1;
            end
        join
    endtask

    // compare every accepted result against the oldest expected one
    always @(posedge clk) begin
        if (!rst && res_valid && res_ready) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("result %h arrived with no block outstanding", res_data);
            end else begin
                check_value(name_q.pop_front(), exp_q.pop_front(), res_data);
            end
        end
    end

    initial begin
        repeat (LIMIT_CYCLES) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", LIMIT_CYCLES);
        $display("tests failed");
        $finish;
    end

    initial begin
        seed      = 32'h9621;
        in_valid  = 1'b0;
        in_data   = 64'd0;
        in_op     = src_pkg::OP_SUM;
        res_ready = 1'b1;
        errors    = 0;
        checks    = 0;
        tests_run = 0;
        mark      = 0;
        @(negedge rst);
        @(negedge clk);

        check_value("reset in_ready", 32'd1, 32'(in_ready));
        check_value("reset res_valid", 32'd0, 32'(res_valid));
        report_test("reset");

        // words 1 to 32, even word from the low half, sum is 528
        for (int i = 0; i < 2 * `SRC_BLOCK_WORDS; i++) begin
            blk_words[i] = 32'(i + 1);
        end
        exp_q.push_back(32'd528);
        name_q.push_back("sum_single");
        drive_block(src_pkg::OP_SUM, 1'b0);
        wait_results;
        report_test("sum_single");

        fill_random;
        send_block(src_pkg::OP_XOR, 1'b0, "xor_random");
        wait_results;
        fill_random;
        send_block(src_pkg::OP_MAX, 1'b0, "max_random");
        wait_results;
        report_test("xor_max_random");

        fill_random;
        send_block(src_pkg::OP_SUM, 1'b0, "back_to_back");
        fill_random;
        send_block(src_pkg::OP_MAX, 1'b0, "back_to_back");
        fill_random;
        send_block(src_pkg::OP_XOR, 1'b0, "back_to_back");
        fill_random;
        send_block(src_pkg::OP_SUM, 1'b0, "back_to_back");
        wait_results;
        report_test("back_to_back");

        run_backpressure;
        wait_results;
        report_test("backpressure");

        fill_random;
        send_block(src_pkg::OP_XOR, 1'b1, "input_gaps");
        fill_random;
        send_block(src_pkg::OP_MAX, 1'b1, "input_gaps");
        wait_results;
        report_test("input_gaps");

        $display("%0d tests run, %0d checks, %0d errors", tests_run, checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: bench/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter int HALF_PERIOD = 10,
    parameter int RST_CYCLES  = 4
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // release on a falling edge, like every other input
    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

// File: hw/bank_ctrl.sv
`timescale 1ns/1ps

module bank_ctrl (
    input  logic              clk,
    input  logic              rst,

    input  logic              blk_done,
    input  src_pkg::src_op_t  blk_op,
    input  logic              rd_release,

    output logic              swap,
    output logic              wr_bank,
    output logic              rd_full,
    output src_pkg::src_op_t  rd_op
);

    // finished block sitting in the write bank
    logic              pending;
    src_pkg::src_op_t  pending_op;

    logic              have_block;
    logic              read_free;

    assign have_block = blk_done | pending;
    // a release this cycle frees the read side for the next edge
    assign read_free  = ~rd_full | rd_release;

    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= 1'b0;
            swap    <= 1'b0;
            wr_bank <= 1'b0;
            rd_full <= 1'b0;
        end else begin
            swap <= have_block & read_free & ~swap;

            if (swap) begin
                pending <= 1'b0;
            end else if (blk_done) begin
                pending <= 1'b1;
            end

            // swap flips ownership and fills the read side
            if (swap) begin
                wr_bank <= ~wr_bank;
                rd_full <= 1'b1;
            end else if (rd_release) begin
                rd_full <= 1'b0;
            end
        end
    end

    // opcode follows its block across the swap
    always_ff @(posedge clk) begin
        if (blk_done) begin
            pending_op <= blk_op;
        end
        if (swap) begin
            rd_op <= pending_op;
        end
    end

endmodule

// File: hw/exec_core.sv
`timescale 1ns/1ps
`include "src_macros.svh"

module exec_core (
    input  logic                      clk,
    input  logic                      rst,

    input  logic                      rd_full,
    input  src_pkg::src_op_t          rd_op,

    output logic                      rd_en,
    output logic [`SRC_RADDR_W-1:0]   rd_addr,
    input  logic [`SRC_WORD_W-1:0]    rd_data,
    output logic                      rd_release,

    output logic                      res_valid,
    input  logic                      res_ready,
    output logic [`SRC_WORD_W-1:0]    res_data
);

    // two 32-bit words per 64-bit beat
    localparam logic [`SRC_RADDR_W-1:0] LAST_ADDR =
        `SRC_RADDR_W'(2 * `SRC_BLOCK_WORDS - 1);

    src_pkg::exec_state_t      state;
    logic [`SRC_RADDR_W-1:0]   addr;
    logic                      rd_vld;
    logic [`SRC_WORD_W-1:0]    acc;

    // one step of the reduction
    function automatic logic [`SRC_WORD_W-1:0] fold(
        input src_pkg::src_op_t        op,
        input logic [`SRC_WORD_W-1:0]  acc_in,
        input logic [`SRC_WORD_W-1:0]  word
    );
        case (op)
            src_pkg::OP_SUM: return acc_in + word;
            src_pkg::OP_XOR: return acc_in ^ word;
            src_pkg::OP_MAX: return (word > acc_in) ? word : acc_in;
            default:         return acc_in;
        endcase
    endfunction

    assign rd_en   = (state == src_pkg::READ);
    assign rd_addr = addr;

    assign res_valid = (state == src_pkg::OUT);
    assign res_data  = acc;

    // bank is free as soon as the result is taken
    assign rd_release = res_valid & res_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= src_pkg::IDLE;
            addr  <= '0;
        end else begin
            case (state)
                src_pkg::IDLE: begin
                    if (rd_full) begin
                        addr  <= '0;
                        state <= src_pkg::READ;
                    end
                end
                src_pkg::READ: begin
                    addr <= addr + 1'b1;
                    if (addr == LAST_ADDR) begin
                        state <= src_pkg::LAST;
                    end
                end
                src_pkg::LAST: begin
                    // last word lands in acc on this edge
                    state <= src_pkg::OUT;
                end
                src_pkg::OUT: begin
                    if (res_ready) begin
                        state <= src_pkg::IDLE;
                    end
                end
                default: begin
                    state <= src_pkg::IDLE;
                end
            endcase
        end
    end

    // read data trails rd_en by one cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_vld <= 1'b0;
        end else begin
            rd_vld <= rd_en;
        end
    end

    // zero is the identity for sum, xor and unsigned max alike
    always_ff @(posedge clk) begin
        if (state == src_pkg::IDLE) begin
            acc <= '0;
        end else if (rd_vld) begin
            acc <= fold(rd_op, acc, rd_data);
        end
    end

endmodule

// File: hw/src_buf.sv
`timescale 1ns/1ps
`include "src_macros.svh"

module src_buf (
    input  logic                      clk,

    input  logic                      wr_en,
    input  logic                      wr_bank,
    input  logic [`SRC_WADDR_W-1:0]   wr_addr,
    input  logic [`SRC_IN_W-1:0]      wr_data,

    input  logic                      rd_en,
    input  logic [`SRC_RADDR_W-1:0]   rd_addr,
    output logic [`SRC_WORD_W-1:0]    rd_data
);

    // first index is the bank, second the entry
    logic [`SRC_WORD_W-1:0] even_ram [0:1][0:`SRC_BANK_DEPTH-1];
    logic [`SRC_WORD_W-1:0] odd_ram  [0:1][0:`SRC_BANK_DEPTH-1];

    logic                      rd_bank;
    logic [`SRC_WADDR_W-1:0]   rd_index;
    logic                      rd_odd;

    // reader always owns the bank the loader is not filling
    assign rd_bank  = ~wr_bank;
    assign rd_index = rd_addr[`SRC_RADDR_W-1:1];
    assign rd_odd   = rd_addr[0];

    // low half is the even word, high half the odd word
    always_ff @(posedge clk) begin
        if (wr_en) begin
            even_ram[wr_bank][wr_addr] <= wr_data[`SRC_WORD_W-1:0];
            odd_ram[wr_bank][wr_addr]  <= wr_data[`SRC_IN_W-1:`SRC_WORD_W];
        end
    end

    // registered read, data valid the cycle after rd_en
    always_ff @(posedge clk) begin
        if (rd_en) begin
            if (rd_odd) begin
                rd_data <= odd_ram[rd_bank][rd_index];
            end else begin
                rd_data <= even_ram[rd_bank][rd_index];
            end
        end
    end

endmodule

// File: hw/src_loader.sv
`timescale 1ns/1ps
`include "src_macros.svh"

module src_loader (
    input  logic                      clk,
    input  logic                      rst,

    input  logic                      in_valid,
    output logic                      in_ready,
    input  logic [`SRC_IN_W-1:0]      in_data,
    input  src_pkg::src_op_t          in_op,

    output logic                      wr_en,
    output logic [`SRC_WADDR_W-1:0]   wr_addr,
    output logic [`SRC_IN_W-1:0]      wr_data,

    output logic                      blk_done,
    output src_pkg::src_op_t          blk_op,
    input  logic                      swap
);

    localparam logic [`SRC_WADDR_W-1:0] LAST_BEAT = `SRC_WADDR_W'(`SRC_BLOCK_WORDS - 1);

    src_pkg::load_state_t      state;
    logic [`SRC_WADDR_W-1:0]   beat_cnt;
    logic                      beat;
    src_pkg::src_op_t          op_q;

    // stream is open only while filling
    assign in_ready = (state == src_pkg::FILL);
    assign beat     = in_valid & in_ready;

    // each accepted beat goes straight into the write bank
    assign wr_en   = beat;
    assign wr_addr = beat_cnt;
    assign wr_data = in_data;

    assign blk_op = op_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= src_pkg::FILL;
            beat_cnt <= '0;
            blk_done <= 1'b0;
        end else begin
            blk_done <= 1'b0;
            case (state)
                src_pkg::FILL: begin
                    if (beat) begin
                        if (beat_cnt == LAST_BEAT) begin
                            beat_cnt <= '0;
                            state    <= src_pkg::WAIT;
                            // report the finished block next cycle
                            blk_done <= 1'b1;
                        end else begin
                            beat_cnt <= beat_cnt + 1'b1;
                        end
                    end
                end
                src_pkg::WAIT: begin
                    // bank_ctrl hands us the other bank
                    if (swap) begin
                        state <= src_pkg::FILL;
                    end
                end
                default: begin
                    state <= src_pkg::FILL;
                end
            endcase
        end
    end

    // opcode belongs to the first beat only
    always_ff @(posedge clk) begin
        if (beat && beat_cnt == '0) begin
            op_q <= in_op;
        end
    end

endmodule

// File: hw/src_pkg.sv
package src_pkg;

    // reduction applied to one block
    typedef enum logic [1:0] {
        OP_SUM = 2'd0,
        OP_XOR = 2'd1,
        OP_MAX = 2'd2
    } src_op_t;

    // exec_core sequencing
    typedef enum logic [1:0] {
        // waiting for a full read bank
        IDLE = 2'd0,
        // issuing read addresses
        READ = 2'd1,
        // final read word in flight
        LAST = 2'd2,
        // result held for the consumer
        OUT  = 2'd3
    } exec_state_t;

    // src_loader sequencing
    typedef enum logic {
        // taking beats
        FILL = 1'b0,
        // block written, waiting for the bank swap
        WAIT = 1'b1
    } load_state_t;

endpackage

// File: hw/src_top.sv
`timescale 1ns/1ps
`include "src_macros.svh"

module src_top (
    input  logic                      clk,
    input  logic                      rst,

    input  logic                      in_valid,
    output logic                      in_ready,
    input  logic [`SRC_IN_W-1:0]      in_data,
    input  src_pkg::src_op_t          in_op,

    output logic                      res_valid,
    input  logic                      res_ready,
    output logic [`SRC_WORD_W-1:0]    res_data
);

    // loader to buffer
    logic                      wr_en;
    logic [`SRC_WADDR_W-1:0]   wr_addr;
    logic [`SRC_IN_W-1:0]      wr_data;

    // loader and core handshakes with bank_ctrl
    logic                      blk_done;
    src_pkg::src_op_t          blk_op;
    logic                      swap;
    logic                      wr_bank;
    logic                      rd_full;
    src_pkg::src_op_t          rd_op;
    logic                      rd_release;

    // core to buffer
    logic                      rd_en;
    logic [`SRC_RADDR_W-1:0]   rd_addr;
    logic [`SRC_WORD_W-1:0]    rd_data;

    src_loader u_loader (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .in_data  (in_data),
        .in_op    (in_op),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .blk_done (blk_done),
        .blk_op   (blk_op),
        .swap     (swap)
    );

    src_buf u_buf (
        .clk     (clk),
        .wr_en   (wr_en),
        .wr_bank (wr_bank),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    bank_ctrl u_bank_ctrl (
        .clk        (clk),
        .rst        (rst),
        .blk_done   (blk_done),
        .blk_op     (blk_op),
        .rd_release (rd_release),
        .swap       (swap),
        .wr_bank    (wr_bank),
        .rd_full    (rd_full),
        .rd_op      (rd_op)
    );

    exec_core u_exec (
        .clk        (clk),
        .rst        (rst),
        .rd_full    (rd_full),
        .rd_op      (rd_op),
        .rd_en      (rd_en),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data),
        .rd_release (rd_release),
        .res_valid  (res_valid),
        .res_ready  (res_ready),
        .res_data   (res_data)
    );

endmodule

// File: include/src_macros.svh
`ifndef SRC_MACROS_SVH
`define SRC_MACROS_SVH

// 64-bit beats in one block
`define SRC_BLOCK_WORDS 16

// input beat and reduced word widths
`define SRC_IN_W 64
`define SRC_WORD_W 32

// write address inside one bank, one per beat
`define SRC_WADDR_W 4

// 32-bit read address, lsb picks even or odd half
`define SRC_RADDR_W 5

// entries in each even and odd ram
`define SRC_BANK_DEPTH 16

`endif

// File: run_sim.sh
#!/bin/sh
# build and run the src_top testbench with Verilator
# the log is searched for the failure line to decide the result

cd "$(dirname "$0")" || exit 1

LOG=sim.log

rm -rf obj_dir "$LOG"

verilator --binary --timing -j 0 --top-module src_top_tb -f src_top.f -o sim_tb \
    && ./obj_dir/sim_tb > "$LOG" 2>&1 \
    || { cat "$LOG" 2>/dev/null; echo "build or simulation run did not complete"; exit 1; }

cat "$LOG"

grep -q "tests failed" "$LOG" && { echo "simulation result: FAIL"; exit 1; }
grep -q "all tests passed" "$LOG" || { echo "simulation result: no pass line"; exit 1; }
echo "simulation result: PASS"
exit 0

// File: src_top.f
+incdir+include
hw/src_pkg.sv
hw/src_loader.sv
hw/src_buf.sv
hw/bank_ctrl.sv
hw/exec_core.sv
hw/src_top.sv
bench/tb_clock.sv
bench/src_top_tb.sv
